/* rtl/soc_pkg.sv */
package soc_pkg;

	// Bus widths
	localparam int haddr_w = 32;
	localparam int hdata_w = 32;

	// External SRAM, 16 bits wide, halfword addressed
	localparam int sram_addr_w = 18;
	localparam int sram_dq_w = 16;
	localparam int sram_half_cycles = 2;                    // Clocks per halfword access
	localparam int sram_cnt_w = $clog2(sram_half_cycles);

	localparam int n_pads = 23;

	// Memory map
	localparam logic [haddr_w-1:0] sram_base = 32'h2000_0000;
	localparam int sram_win_w = 19;                         // 512 KiB window
	localparam logic [haddr_w-1:0] gpio_base = 32'h4000_0000;
	localparam int gpio_ofs_w = 12;                         // 4 KiB window

	// GPIO register offsets
	localparam logic [gpio_ofs_w-1:0] gpio_out_ofs = 12'h000;
	localparam logic [gpio_ofs_w-1:0] gpio_oe_ofs = 12'h004;
	localparam logic [gpio_ofs_w-1:0] gpio_in_ofs = 12'h008; // Read only

	typedef enum logic [1:0] {
		htrans_idle   = 2'b00,
		htrans_busy   = 2'b01,
		htrans_nonseq = 2'b10,
		htrans_seq    = 2'b11
	} htrans_t;

	typedef enum logic [2:0] {
		hsize_byte = 3'b000,
		hsize_half = 3'b001,
		hsize_word = 3'b010
	} hsize_t;

	// One bus word seen whole or as two SRAM halfwords, half[0] at the even address
	typedef union packed {
		logic [hdata_w-1:0] word;
		logic [1:0][sram_dq_w-1:0] half;
	} sram_word_t;

endpackage

/* rtl/ahb_if.sv */
`timescale 1ns/1ps

interface ahb_if
	import soc_pkg::*;
();

	// Address phase, from the decoder
	logic sel;
	logic [haddr_w-1:0] haddr;
	htrans_t htrans;
	logic hwrite;
	hsize_t hsize;
	logic [hdata_w-1:0] hwdata;
	logic hready_in;                // Global hready, broadcast to every slave

	// Response, from the slave
	logic [hdata_w-1:0] hrdata;
	logic hreadyout;
	logic hresp;

	modport master (
		output sel, haddr, htrans, hwrite, hsize, hwdata, hready_in,
		input  hrdata, hreadyout, hresp
	);

	modport slave (
		input  sel, haddr, htrans, hwrite, hsize, hwdata, hready_in,
		output hrdata, hreadyout, hresp
	);

endinterface

/* rtl/ahb_decoder.sv */
`timescale 1ns/1ps

module ahb_decoder import soc_pkg::*; (
	input  logic clk_sys,
	input  logic rst_n,
	input  logic [haddr_w-1:0] haddr,
	input  htrans_t htrans,
	input  logic hwrite,
	input  hsize_t hsize,
	input  logic [hdata_w-1:0] hwdata,
	output logic [hdata_w-1:0] hrdata,
	output logic hready,
	output logic hresp,
	ahb_if.master sram_bus,
	ahb_if.master gpio_bus
);

	logic xfer;
	logic hit_sram;
	logic hit_gpio;
	logic dph_sram;
	logic dph_gpio;
	logic dph_err;
	logic err_second;

	assign xfer = htrans inside {htrans_nonseq, htrans_seq};
	assign hit_sram = haddr[haddr_w-1:sram_win_w] == sram_base[haddr_w-1:sram_win_w];
	assign hit_gpio = haddr[haddr_w-1:gpio_ofs_w] == gpio_base[haddr_w-1:gpio_ofs_w];

	// Address phase goes to both slaves, sel picks one
	assign sram_bus.sel = hit_sram;
	assign sram_bus.haddr = haddr;
	assign sram_bus.htrans = htrans;
	assign sram_bus.hwrite = hwrite;
	assign sram_bus.hsize = hsize;
	assign sram_bus.hwdata = hwdata;
	assign sram_bus.hready_in = hready;

	assign gpio_bus.sel = hit_gpio;
	assign gpio_bus.haddr = haddr;
	assign gpio_bus.htrans = htrans;
	assign gpio_bus.hwrite = hwrite;
	assign gpio_bus.hsize = hsize;
	assign gpio_bus.hwdata = hwdata;
	assign gpio_bus.hready_in = hready;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			dph_sram <= 1'b0;
			dph_gpio <= 1'b0;
			dph_err <= 1'b0;
			err_second <= 1'b0;
		end else if (hready) begin
			dph_sram <= xfer && hit_sram;
			dph_gpio <= xfer && hit_gpio;
			dph_err <= xfer && !hit_sram && !hit_gpio; // Unmapped
			err_second <= 1'b0;
		end else if (dph_err) begin
			err_second <= 1'b1;
		end
	end

	always_comb begin
		if (dph_sram) begin
			hrdata = sram_bus.hrdata;
			hready = sram_bus.hreadyout;
			hresp = sram_bus.hresp;
		end else if (dph_gpio) begin
			hrdata = gpio_bus.hrdata;
			hready = gpio_bus.hreadyout;
			hresp = gpio_bus.hresp;
		end else if (dph_err) begin
			hrdata = '0;
			hready = err_second;                    // Low first, high second
			hresp = 1'b1;
		end else begin
			hrdata = '0;
			hready = 1'b1;
			hresp = 1'b0;
		end
	end

endmodule

/* rtl/sram_ctrl.sv */
`timescale 1ns/1ps

module sram_ctrl import soc_pkg::*; (
	input  logic clk_sys,
	input  logic rst_n,
	ahb_if.slave bus,
	output logic [sram_addr_w-1:0] sram_addr,
	output logic [sram_dq_w-1:0] sram_dq_out,
	output logic sram_dq_oe,
	input  logic [sram_dq_w-1:0] sram_dq_in,
	output logic sram_ce_n,
	output logic sram_we_n,
	output logic sram_oe_n,
	output logic [1:0] sram_byte_n
);

	localparam logic [sram_cnt_w-1:0] cnt_last = sram_cnt_w'(sram_half_cycles - 1);

	logic accept;
	logic active;
	logic write;
	logic is_word;
	logic second;                                   // Upper halfword of a word access
	logic [sram_cnt_w-1:0] hw_cnt;
	logic half_last;
	logic last_cycle;
	logic [sram_dq_w-1:0] rdata_lo;
	sram_word_t wdata_u;
	sram_word_t rdata_u;

	assign accept = bus.sel && bus.hready_in && (bus.htrans inside {htrans_nonseq, htrans_seq});
	assign half_last = hw_cnt == cnt_last;
	assign last_cycle = active && half_last && (!is_word || second);

	assign bus.hreadyout = !active || last_cycle;
	assign bus.hresp = 1'b0;

	// Halfword follows the SRAM address LSB, so sub-word writes land on the right lane
	assign wdata_u.word = bus.hwdata;
	assign sram_dq_out = wdata_u.half[sram_addr[0]];

	// Last halfword comes straight off the pins on the final edge
	always_comb begin
		rdata_u.half[1] = sram_dq_in;
		rdata_u.half[0] = is_word ? rdata_lo : sram_dq_in;
	end
	assign bus.hrdata = rdata_u.word;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			active <= 1'b0;
			write <= 1'b0;
			is_word <= 1'b0;
			second <= 1'b0;
			hw_cnt <= '0;
			sram_addr <= '0;
			sram_ce_n <= 1'b1;
			sram_we_n <= 1'b1;
			sram_oe_n <= 1'b1;
			sram_dq_oe <= 1'b0;
			sram_byte_n <= 2'b11;
		end else if (accept) begin
			active <= 1'b1;
			write <= bus.hwrite;
			is_word <= bus.hsize == hsize_word;
			second <= 1'b0;
			hw_cnt <= '0;
			sram_addr <= bus.haddr[sram_addr_w:1];  // Byte to halfword address
			sram_ce_n <= 1'b0;
			sram_we_n <= !bus.hwrite;
			sram_oe_n <= bus.hwrite;
			sram_dq_oe <= bus.hwrite;
			if (bus.hsize == hsize_byte)
				sram_byte_n <= bus.haddr[0] ? 2'b01 : 2'b10;
			else
				sram_byte_n <= 2'b00;
		end else if (last_cycle) begin
			active <= 1'b0;
			sram_ce_n <= 1'b1;
			sram_we_n <= 1'b1;
			sram_oe_n <= 1'b1;
			sram_dq_oe <= 1'b0;
			sram_byte_n <= 2'b11;
		end else if (active) begin
			if (half_last) begin
				second <= 1'b1;
				hw_cnt <= '0;
				sram_addr[0] <= 1'b1;           // Odd halfword next
				sram_we_n <= !write;
			end else begin
				hw_cnt <= hw_cnt + 1'b1;
				sram_we_n <= 1'b1;              // Strobe only in the first clock
			end
		end
	end

	// Low halfword of a word read, captured as its cycle ends
	always_ff @(posedge clk_sys) begin
		if (active && half_last && !second)
			rdata_lo <= sram_dq_in;
	end

endmodule

/* rtl/gpio_regs.sv */
`timescale 1ns/1ps

module gpio_regs import soc_pkg::*; (
	input  logic clk_sys,
	input  logic rst_n,
	ahb_if.slave bus,
	output logic [n_pads-1:0] padout,
	output logic [n_pads-1:0] padoe,
	input  logic [n_pads-1:0] padin
);

	logic accept;
	logic dph_write;
	logic [gpio_ofs_w-3:0] dph_ofs;                 // Word offset
	logic [n_pads-1:0] padin_meta;
	logic [n_pads-1:0] padin_sync;
	logic wr_en;

	assign accept = bus.sel && bus.hready_in && (bus.htrans inside {htrans_nonseq, htrans_seq});
	assign wr_en = dph_write && bus.hready_in;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			dph_write <= 1'b0;
			dph_ofs <= '0;
		end else if (bus.hready_in) begin
			dph_write <= accept && bus.hwrite;
			dph_ofs <= bus.haddr[gpio_ofs_w-1:2];
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			padout <= '0;
			padoe <= '0;
		end else if (wr_en) begin
			if (dph_ofs == gpio_out_ofs[gpio_ofs_w-1:2])
				padout <= bus.hwdata[n_pads-1:0];
			if (dph_ofs == gpio_oe_ofs[gpio_ofs_w-1:2])
				padoe <= bus.hwdata[n_pads-1:0];
		end
	end

	// Two-flop synchroniser on the pad inputs
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			padin_meta <= '0;
			padin_sync <= '0;
		end else begin
			padin_meta <= padin;
			padin_sync <= padin_meta;
		end
	end

	always_comb begin
		bus.hrdata = '0;
		if (dph_ofs == gpio_out_ofs[gpio_ofs_w-1:2])
			bus.hrdata[n_pads-1:0] = padout;
		else if (dph_ofs == gpio_oe_ofs[gpio_ofs_w-1:2])
			bus.hrdata[n_pads-1:0] = padoe;
		else if (dph_ofs == gpio_in_ofs[gpio_ofs_w-1:2])
			bus.hrdata[n_pads-1:0] = padin_sync;
	end

	assign bus.hreadyout = 1'b1;                    // Zero wait states
	assign bus.hresp = 1'b0;

endmodule

/* rtl/soc_mem_io.sv */
`timescale 1ns/1ps

module soc_mem_io import soc_pkg::*; (
	input  logic clk_sys,
	input  logic rst_n,
	input  logic [haddr_w-1:0] haddr,
	input  htrans_t htrans,
	input  logic hwrite,
	input  hsize_t hsize,
	input  logic [hdata_w-1:0] hwdata,
	output logic [hdata_w-1:0] hrdata,
	output logic hready,
	output logic hresp,
	output logic [sram_addr_w-1:0] sram_addr,
	output logic [sram_dq_w-1:0] sram_dq_out,
	output logic sram_dq_oe,
	input  logic [sram_dq_w-1:0] sram_dq_in,
	output logic sram_ce_n,
	output logic sram_we_n,
	output logic sram_oe_n,
	output logic [1:0] sram_byte_n,
	output logic [n_pads-1:0] padout,
	output logic [n_pads-1:0] padoe,
	input  logic [n_pads-1:0] padin
);

	ahb_if sram_bus ();
	ahb_if gpio_bus ();

	ahb_decoder i_ahb_decoder (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.haddr    (haddr),
		.htrans   (htrans),
		.hwrite   (hwrite),
		.hsize    (hsize),
		.hwdata   (hwdata),
		.hrdata   (hrdata),
		.hready   (hready),
		.hresp    (hresp),
		.sram_bus (sram_bus.master),
		.gpio_bus (gpio_bus.master)
	);

	sram_ctrl i_sram_ctrl (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.bus         (sram_bus.slave),
		.sram_addr   (sram_addr),
		.sram_dq_out (sram_dq_out),
		.sram_dq_oe  (sram_dq_oe),
		.sram_dq_in  (sram_dq_in),
		.sram_ce_n   (sram_ce_n),
		.sram_we_n   (sram_we_n),
		.sram_oe_n   (sram_oe_n),
		.sram_byte_n (sram_byte_n)
	);

	gpio_regs i_gpio_regs (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.bus     (gpio_bus.slave),
		.padout  (padout),
		.padoe   (padoe),
		.padin   (padin)
	);

endmodule

/* tests/sram_model.sv */
`timescale 1ns/1ps

module sram_model import soc_pkg::*; (
	input  logic [sram_addr_w-1:0] sram_addr,
	input  logic [sram_dq_w-1:0] sram_dq_out,
	input  logic sram_dq_oe,
	output logic [sram_dq_w-1:0] sram_dq_in,
	input  logic sram_ce_n,
	input  logic sram_we_n,
	input  logic sram_oe_n,
	input  logic [1:0] sram_byte_n
);

	logic [sram_dq_w-1:0] mem [0:(1 << sram_addr_w)-1];    // One entry per halfword

	// Data is taken as the write strobe rises
	always @(posedge sram_we_n) begin
		if (!sram_ce_n && sram_dq_oe) begin
			if (!sram_byte_n[0])
				mem[sram_addr][7:0] <= sram_dq_out[7:0];     // Lower byte lane
			if (!sram_byte_n[1])
				mem[sram_addr][15:8] <= sram_dq_out[15:8];   // Upper byte lane
		end
	end

	// Asynchronous read while chip and output enables are low
	assign sram_dq_in = (!sram_ce_n && !sram_oe_n) ? mem[sram_addr] : '0;

endmodule

/* tests/tb.sv */
`timescale 1ns/1ps

module tb import soc_pkg::*; ();

	localparam int max_cycles = 5000;                       // Tests need well under 2000
	localparam logic [haddr_w-1:0] word_ofs_mask = haddr_w'((1 << sram_win_w) - 4);
	localparam logic [haddr_w-1:0] gpio_out_addr = gpio_base | haddr_w'(gpio_out_ofs);
	localparam logic [haddr_w-1:0] gpio_oe_addr = gpio_base | haddr_w'(gpio_oe_ofs);
	localparam logic [haddr_w-1:0] gpio_in_addr = gpio_base | haddr_w'(gpio_in_ofs);
	localparam logic [haddr_w-1:0] unmapped_addr = 32'h6000_0000;

	logic clk_sys;
	logic rst_n;
	logic [haddr_w-1:0] haddr;
	htrans_t htrans;
	logic hwrite;
	hsize_t hsize;
	logic [hdata_w-1:0] hwdata;
	logic [hdata_w-1:0] hrdata;
	logic hready;
	logic hresp;
	logic [sram_addr_w-1:0] sram_addr;
	logic [sram_dq_w-1:0] sram_dq_out;
	logic sram_dq_oe;
	logic [sram_dq_w-1:0] sram_dq_in;
	logic sram_ce_n;
	logic sram_we_n;
	logic sram_oe_n;
	logic [1:0] sram_byte_n;
	logic [n_pads-1:0] padout;
	logic [n_pads-1:0] padoe;
	logic [n_pads-1:0] padin;

	int seed = 32'he049;
	int cycles = 0;
	int checks = 0;
	int errors = 0;
	string test_name = "";
	int last_waits;                                         // Data-phase cycles with hready low
	logic last_wait_resp;                                   // hresp seen during those cycles
	logic [hdata_w-1:0] ref_words [logic [haddr_w-1:0]];   // Expected SRAM words by address

	soc_mem_io i_soc_mem_io (.*);
	sram_model i_sram_model (.*);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycles = cycles + 1;
		if (cycles >= max_cycles) begin
			$display("Timeout: the tests did not complete within %0d cycles", max_cycles);
			$display("Checks: %0d, errors: %0d", checks, errors);
			$display("Regression failed");
			$finish;
		end
	end

	task automatic compare_word(input string what, input logic [hdata_w-1:0] exp,
			input logic [hdata_w-1:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Mismatch in %s, %s: expected %h, actual %h", test_name, what, exp, act);
		end
	endtask

	task automatic compare_pads(input string what, input logic [n_pads-1:0] exp,
			input logic [n_pads-1:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Mismatch in %s, %s: expected %h, actual %h", test_name, what, exp, act);
		end
	endtask

	task automatic compare_resp(input string what, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Mismatch in %s, %s: expected %b, actual %b", test_name, what, exp, act);
		end
	endtask

	task automatic compare_bit(input string what, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Mismatch in %s, %s: expected %b, actual %b", test_name, what, exp, act);
		end
	endtask

	task automatic compare_count(input string what, input int exp, input int act);
		checks++;
		if (act != exp) begin
			errors++;
			$display("Mismatch in %s, %s: expected %0d, actual %0d", test_name, what, exp, act);
		end
	endtask

	// Single AHB transfer entered and left on a falling edge
	task automatic ahb_transfer(input logic wr, input logic [haddr_w-1:0] addr,
			input hsize_t size, input logic [hdata_w-1:0] wdata,
			output logic [hdata_w-1:0] rdata, output logic resp);
		haddr = addr;
		htrans = htrans_nonseq;
		hwrite = wr;
		hsize = size;
		while (!hready)
			@(negedge clk_sys);
		@(negedge clk_sys);                                 // Address taken on that rising edge
		htrans = htrans_idle;
		hwdata = wdata;
		last_waits = 0;
		last_wait_resp = 1'b0;
		while (!hready) begin
			last_waits++;
			last_wait_resp = last_wait_resp | hresp;
			@(negedge clk_sys);
		end
		rdata = hrdata;
		resp = hresp;
		@(negedge clk_sys);
	endtask

	task automatic ahb_write(input logic [haddr_w-1:0] addr, input hsize_t size,
			input logic [hdata_w-1:0] data, output logic resp);
		logic [hdata_w-1:0] unused_rdata;
		ahb_transfer(1'b1, addr, size, data, unused_rdata, resp);
	endtask

	task automatic ahb_read(input logic [haddr_w-1:0] addr, input hsize_t size,
			output logic [hdata_w-1:0] rdata, output logic resp);
		ahb_transfer(1'b0, addr, size, '0, rdata, resp);
	endtask

	// Byte lanes touched by a transfer of this size at this address
	function automatic logic [hdata_w-1:0] lane_mask(input hsize_t size, input logic [1:0] ofs);
		case (size)
			hsize_byte: lane_mask = 32'h0000_00ff << (8 * ofs);
			hsize_half: lane_mask = 32'h0000_ffff << (16 * ofs[1]);
			default: lane_mask = '1;
		endcase
	endfunction

	task automatic test_reset();
		logic [hdata_w-1:0] data;
		logic resp;
		test_name = "reset state";
		compare_pads("padout", '0, padout);
		compare_pads("padoe", '0, padoe);
		compare_bit("sram_ce_n", 1'b1, sram_ce_n);
		compare_bit("sram_we_n", 1'b1, sram_we_n);
		compare_bit("sram_oe_n", 1'b1, sram_oe_n);
		compare_bit("sram_dq_oe", 1'b0, sram_dq_oe);
		compare_bit("hready", 1'b1, hready);
		compare_resp("hresp", 1'b0, hresp);
		ahb_read(gpio_out_addr, hsize_word, data, resp);
		compare_word("OUT read", '0, data);
		compare_resp("OUT read", 1'b0, resp);
	endtask

	task automatic test_words();
		logic [haddr_w-1:0] addrs [$];
		logic [haddr_w-1:0] addr;
		logic [hdata_w-1:0] data;
		logic [hdata_w-1:0] exp;
		logic [sram_addr_w-1:0] hw;
		logic resp;
		test_name = "word traffic";
		repeat (16) begin
			addr = sram_base | (haddr_w'($random(seed)) & word_ofs_mask);
			data = $random(seed);
			ahb_write(addr, hsize_word, data, resp);
			compare_resp("write", 1'b0, resp);
			compare_count("write wait states", 3, last_waits);
			ref_words[addr] = data;
			addrs.push_back(addr);
		end
		foreach (addrs[i]) begin
			exp = ref_words[addrs[i]];
			ahb_read(addrs[i], hsize_word, data, resp);
			compare_word("read", exp, data);
			compare_resp("read", 1'b0, resp);
			compare_count("read wait states", 3, last_waits);
			hw = addrs[i][sram_addr_w:1];                   // Even halfword of the word
			compare_word("low half at even address", hdata_w'(exp[sram_dq_w-1:0]),
				hdata_w'(i_sram_model.mem[hw]));
		end
	endtask

	task automatic test_sub_word();
		logic [haddr_w-1:0] base;
		logic [haddr_w-1:0] addr;
		logic [hdata_w-1:0] data;
		logic [hdata_w-1:0] exp;
		logic [hdata_w-1:0] mask;
		hsize_t size;
		logic resp;
		test_name = "sub-word writes";
		for (int w = 0; w < 2; w++) begin
			if (w == 0)
				base = sram_base + 32'h0000_0100;
			else
				base = sram_base + 32'h0007_fff8;           // Top of the window
			exp = $random(seed);
			ahb_write(base, hsize_word, exp, resp);
			for (int k = 0; k < 6; k++) begin
				if (k < 4) begin
					size = hsize_byte;
					addr = base + haddr_w'(k);
				end else begin
					size = hsize_half;
					addr = base + haddr_w'(2 * (k - 4));
				end
				data = $random(seed);
				ahb_write(addr, size, data, resp);
				compare_resp("sub-word write", 1'b0, resp);
				compare_count("sub-word wait states", 1, last_waits);
				mask = lane_mask(size, addr[1:0]);
				exp = (exp & ~mask) | (data & mask);
				ahb_read(base, hsize_word, data, resp);
				compare_word("word after sub-word write", exp, data);
			end
		end
	endtask

	task automatic test_gpio_out();
		logic [n_pads-1:0] out_v;
		logic [n_pads-1:0] oe_v;
		logic [hdata_w-1:0] data;
		logic resp;
		test_name = "GPIO outputs";
		repeat (4) begin
			out_v = n_pads'($random(seed));
			oe_v = n_pads'($random(seed));
			ahb_write(gpio_out_addr, hsize_word, hdata_w'(out_v), resp);
			compare_count("write wait states", 0, last_waits);
			compare_pads("padout", out_v, padout);
			ahb_write(gpio_oe_addr, hsize_word, hdata_w'(oe_v), resp);
			compare_pads("padoe", oe_v, padoe);
			ahb_read(gpio_out_addr, hsize_word, data, resp);
			compare_word("OUT read", hdata_w'(out_v), data);
			ahb_read(gpio_oe_addr, hsize_word, data, resp);
			compare_word("OE read", hdata_w'(oe_v), data);
			compare_resp("OE read", 1'b0, resp);
		end
	endtask

	task automatic test_gpio_in();
		logic [n_pads-1:0] pads;
		logic [hdata_w-1:0] data;
		logic resp;
		test_name = "GPIO inputs";
		repeat (4) begin
			pads = n_pads'($random(seed));
			padin = pads;
			repeat (3) @(negedge clk_sys);                  // Synchroniser latency
			ahb_read(gpio_in_addr, hsize_word, data, resp);
			compare_word("IN read", hdata_w'(pads), data);
		end
	endtask

	task automatic check_error(input string what, input logic resp);
		compare_resp({what, " first cycle hresp"}, 1'b1, last_wait_resp);
		compare_count({what, " cycles with hready low"}, 1, last_waits);
		compare_resp({what, " second cycle hresp"}, 1'b1, resp);
	endtask

	task automatic test_unmapped();
		logic [haddr_w-1:0] addr;
		logic [hdata_w-1:0] data;
		logic [hdata_w-1:0] exp;
		logic resp;
		test_name = "unmapped access";
		ahb_read(unmapped_addr, hsize_word, data, resp);
		check_error("read", resp);
		ahb_write(unmapped_addr, hsize_word, 32'hdead_beef, resp);
		check_error("write", resp);
		addr = sram_base + 32'h0000_0200;
		exp = $random(seed);
		ahb_write(addr, hsize_word, exp, resp);
		compare_resp("following write", 1'b0, resp);
		ahb_read(addr, hsize_word, data, resp);
		compare_resp("following read", 1'b0, resp);
		compare_word("following read", exp, data);
		compare_count("following read wait states", 3, last_waits);
	endtask

	initial begin
		rst_n = 1'b0;
		haddr = '0;
		htrans = htrans_idle;
		hwrite = 1'b0;
		hsize = hsize_word;
		hwdata = '0;
		padin = '0;
		repeat (10) @(negedge clk_sys);
		rst_n = 1'b1;
		@(negedge clk_sys);
		test_reset();
		test_words();
		test_sub_word();
		test_gpio_out();
		test_gpio_in();
		test_unmapped();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

/* project.f */
rtl/soc_pkg.sv
rtl/ahb_if.sv
rtl/ahb_decoder.sv
rtl/sram_ctrl.sv
rtl/gpio_regs.sv
rtl/soc_mem_io.sv
tests/sram_model.sv
tests/tb.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f project.f --top-module tb -o tb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Regression failed" sim.log; then
	exit 1
fi
exit 0
